/* files.f */
+incdir+verilog
verilog/hwloop_pkg.sv
verilog/hwloop_cmd_decoder.sv
verilog/hwloop_regs.sv
verilog/hwloop_controller.sv
verilog/pc_sequencer.sv
verilog/hwloop_unit.sv
tb/hwloop_unit_tb.sv

/* Makefile */
# Verilator build and run of the hardware loop unit testbench

VERILATOR ?= verilator
TOP       ?= hwloop_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/hwloop_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module hwloop_unit_tb import hwloop_pkg::*; ();

  localparam int MAX_ROWS = 9;
  localparam int MAX_CMDS = 6;
  localparam int MAX_RET  = 64;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  hwlp_op_e    cmd_op;
  hwlp_idx_t   cmd_idx;
  logic [31:0] cmd_data;
  logic        pc_valid;
  logic        pc_ready;
  hwlp_addr_t  pc;
  logic        pc_from_loop;

  // 100 ns period
  always #50 clk = ~clk;

  hwloop_unit hwloop_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .cmd_op_i       (cmd_op),
    .cmd_idx_i      (cmd_idx),
    .cmd_data_i     (cmd_data),
    .pc_valid_o     (pc_valid),
    .pc_ready_i     (pc_ready),
    .pc_o           (pc),
    .pc_from_loop_o (pc_from_loop)
  );

  ////////////////////
  // stimulus table
  ////////////////////

  // start and end data are offsets from the pc where the row begins
  string       row_name [MAX_ROWS];
  int          row_ncmd [MAX_ROWS];
  int          row_nret [MAX_ROWS];
  bit          row_live [MAX_ROWS];
  bit          row_bp   [MAX_ROWS];
  hwlp_op_e    tab_op   [MAX_ROWS][MAX_CMDS];
  hwlp_idx_t   tab_idx  [MAX_ROWS][MAX_CMDS];
  logic [31:0] tab_data [MAX_ROWS][MAX_CMDS];
  int          n_rows    = 0;
  int          total_ret = 0;

  // model state holds the loop registers plus the presented pc
  hwlp_addr_t m_start [`HWLP_N_REGS];
  hwlp_addr_t m_end   [`HWLP_N_REGS];
  hwlp_cnt_t  m_cnt   [`HWLP_N_REGS];
  hwlp_addr_t m_pc;
  logic       m_loop;
  // expected pc and from-loop flag for each presented pc
  hwlp_addr_t exp_pc   [MAX_RET+1];
  logic       exp_loop [MAX_RET+1];

  int errors = 0;
  int cycles = 0;
  int limit;
  int n_pass = 0;
  int n_fail = 0;

  task automatic add_row(input string name, input int nret, input bit live, input bit bp);
    row_name[n_rows] = name;
    row_nret[n_rows] = nret;
    row_live[n_rows] = live;
    row_bp[n_rows]   = bp;
    row_ncmd[n_rows] = 0;
    total_ret += nret;
    n_rows++;
  endtask

  // appends to the newest row
  task automatic add_cmd(input hwlp_op_e op, input int idx, input logic [31:0] data);
    int r;
    r = n_rows - 1;
    tab_op[r][row_ncmd[r]]   = op;
    tab_idx[r][row_ncmd[r]]  = hwlp_idx_t'(idx);
    tab_data[r][row_ncmd[r]] = data;
    row_ncmd[r]++;
  endtask

  task automatic add_loop(input int idx, input int s, input int e, input int c);
    add_cmd(OP_SET_START, idx, 32'(s));
    add_cmd(OP_SET_END, idx, 32'(e));
    add_cmd(OP_SET_COUNT, idx, 32'(c));
  endtask

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_addr(input string name, input hwlp_addr_t exp, input hwlp_addr_t act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // one retire of m_pc where the lowest matching loop wins
  task automatic model_retire();
    int         win;
    hwlp_addr_t seq;
    win = -1;
    seq = m_pc + 32'd4;
    for (int i = 0; i < `HWLP_N_REGS; i++) begin
      if (win < 0 && m_end[i] == seq && m_cnt[i] != 0) begin
        win = i;
      end
    end
    m_loop = 1'b0;
    m_pc   = seq;
    if (win >= 0) begin
      // jump back only while another pass remains
      if (m_cnt[win] >= 2) begin
        m_pc   = m_start[win];
        m_loop = 1'b1;
      end
      m_cnt[win] = m_cnt[win] - 1;
    end
  endtask

  // load the row into the model, then predict each presented pc
  task automatic build_expect(input int r, input hwlp_addr_t base);
    hwlp_idx_t i;
    for (int c = 0; c < row_ncmd[r]; c++) begin
      i = tab_idx[r][c];
      case (tab_op[r][c])
        OP_SET_START: m_start[i] = (base + tab_data[r][c]) & ~32'h3;
        OP_SET_END:   m_end[i]   = (base + tab_data[r][c]) & ~32'h3;
        default:      m_cnt[i]   = tab_data[r][c];
      endcase
    end
    for (int k = 0; k < row_nret[r]; k++) begin
      exp_pc[k]   = m_pc;
      exp_loop[k] = m_loop;
      model_retire();
    end
    exp_pc[row_nret[r]]   = m_pc;
    exp_loop[row_nret[r]] = m_loop;
  endtask

  task automatic run_row(input int r);
    int         ci;
    int         k;
    int         gap;
    int         settle;
    int         err0;
    logic       go;
    hwlp_addr_t base;
    ci     = 0;
    k      = 0;
    settle = 0;
    err0   = errors;
    gap    = int'($urandom % 3);
    base   = m_pc;
    // live rows touch only a loop whose end lies far ahead
    build_expect(r, base);
    while (k < row_nret[r] || ci < row_ncmd[r] || settle < 2) begin
      @(negedge clk);
      // pc must hold until it retires
      check_addr("pc_o", exp_pc[k], pc);
      check_bit("pc_from_loop_o", exp_loop[k], pc_from_loop);
      check_bit("pc_valid_o", 1'b1, pc_valid);
      if (ci == row_ncmd[r] && settle < 2) begin
        settle++;
      end
      // setup rows wait two cycles for the last write to land
      go = (k < row_nret[r]) && (row_live[r] || settle >= 2);
      if (row_bp[r] && $urandom % 4 == 0) begin
        go = 1'b0;
      end
      pc_ready  = go;
      cmd_valid = 1'b0;
      if (ci < row_ncmd[r]) begin
        if (gap > 0) begin
          gap--;
        end else begin
          cmd_valid = 1'b1;
          cmd_op    = tab_op[r][ci];
          cmd_idx   = tab_idx[r][ci];
          cmd_data  = (cmd_op == OP_SET_COUNT) ? tab_data[r][ci] : base + tab_data[r][ci];
        end
      end
      // ready settles well before the rising edge
      #1;
      if (cmd_valid) begin
        // the loop under decrement is never the target so no stall is allowed
        check_bit("cmd_ready_o", 1'b1, cmd_ready);
        if (cmd_ready) begin
          ci++;
          gap = int'($urandom % 3);
        end
      end
      if (go) begin
        k++;
      end
    end
    if (errors == err0) begin
      n_pass++;
      $display("test %0d %s ok, %0d pcs retired", r, row_name[r], k);
    end else begin
      n_fail++;
      $display("test %0d %s had %0d mismatches", r, row_name[r], errors - err0);
    end
  endtask

  // run limit scales with the retires in the table
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, a pc or command handshake never came", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9320f8cf));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_SET_START;
    cmd_idx   = '0;
    cmd_data  = '0;
    pc_ready  = 1'b0;
    m_pc      = `HWLP_RESET_PC;
    m_loop    = 1'b0;
    for (int i = 0; i < `HWLP_N_REGS; i++) begin
      m_start[i] = '0;
      m_end[i]   = '0;
      m_cnt[i]   = '0;
    end
    add_row("reset_step", 6, 1'b0, 1'b0);
    add_row("single_loop", 16, 1'b0, 1'b0);
    add_loop(0, 8, 20, 3);
    // loop 0 is the inner loop and loop 1 the outer one
    add_row("nested", 16, 1'b0, 1'b0);
    add_loop(0, 4, 12, 2);
    add_loop(1, 0, 20, 2);
    add_row("shared_end", 10, 1'b0, 1'b0);
    add_loop(0, 8, 16, 2);
    add_loop(1, 0, 16, 2);
    // loop 1 runs on the count left from shared_end
    add_row("count_one", 12, 1'b0, 1'b0);
    add_loop(0, 4, 12, 1);
    add_cmd(OP_SET_START, 1, 32'd0);
    add_cmd(OP_SET_END, 1, 32'd16);
    // a zero count loop 0 must leave the shared end to loop 1
    add_row("count_zero", 8, 1'b0, 1'b0);
    add_loop(0, 4, 12, 0);
    add_loop(1, 0, 12, 2);
    add_row("backpressure", 16, 1'b0, 1'b1);
    add_loop(0, 8, 20, 3);
    add_row("live_setup", 0, 1'b0, 1'b0);
    add_loop(0, 0, 12, 8);
    add_row("live_reprog", 34, 1'b1, 1'b1);
    add_loop(1, 0, 16, 2);
    limit = total_ret * 4 + 200;
    // stream stays invalid through reset
    repeat (16) begin
      @(negedge clk);
      check_bit("pc_valid_o", 1'b0, pc_valid);
    end
    rst_n = 1'b1;
    #1;
    check_bit("cmd_ready_o", 1'b1, cmd_ready);
    check_addr("pc_o", `HWLP_RESET_PC, pc);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    // last retire lands on the next edge
    @(negedge clk);
    check_addr("pc_o", m_pc, pc);
    $display("summary %0d tests ok, %0d tests bad, %0d mismatches", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/hwloop_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module hwloop_unit import hwloop_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // setup commands
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  hwlp_op_e    cmd_op_i,
  input  hwlp_idx_t   cmd_idx_i,
  input  logic [31:0] cmd_data_i,
  // pc stream
  output logic        pc_valid_o,
  input  logic        pc_ready_i,
  output hwlp_addr_t  pc_o,
  output logic        pc_from_loop_o
);

  // decoder to regs
  logic        wr_en;
  hwlp_op_e    wr_op;
  hwlp_idx_t   wr_idx;
  logic [31:0] wr_data;

  // regs to controller
  hwlp_addr_t start_addr [`HWLP_N_REGS];
  hwlp_addr_t end_addr   [`HWLP_N_REGS];
  hwlp_cnt_t  count      [`HWLP_N_REGS];

  // controller outputs
  logic [`HWLP_N_REGS-1:0] dec_cnt;
  logic                    hwlp_jump;
  hwlp_addr_t              hwlp_targ_addr;

  logic retire;

  hwloop_cmd_decoder hwloop_cmd_decoder_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_idx_i   (cmd_idx_i),
    .cmd_data_i  (cmd_data_i),
    .dec_cnt_i   (dec_cnt),
    .wr_en_o     (wr_en),
    .wr_op_o     (wr_op),
    .wr_idx_o    (wr_idx),
    .wr_data_o   (wr_data)
  );

  hwloop_regs hwloop_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en_i      (wr_en),
    .wr_op_i      (wr_op),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .dec_cnt_i    (dec_cnt),
    .start_addr_o (start_addr),
    .end_addr_o   (end_addr),
    .count_o      (count)
  );

  // current pc is the presented one
  hwloop_controller hwloop_controller_i (
    .cur_pc_i         (pc_o),
    .retire_i         (retire),
    .start_addr_i     (start_addr),
    .end_addr_i       (end_addr),
    .count_i          (count),
    .hwlp_jump_o      (hwlp_jump),
    .hwlp_targ_addr_o (hwlp_targ_addr),
    .dec_cnt_o        (dec_cnt)
  );

  pc_sequencer pc_sequencer_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_valid_o       (pc_valid_o),
    .pc_ready_i       (pc_ready_i),
    .pc_o             (pc_o),
    .pc_from_loop_o   (pc_from_loop_o),
    .hwlp_jump_i      (hwlp_jump),
    .hwlp_targ_addr_i (hwlp_targ_addr),
    .retire_o         (retire)
  );

endmodule

`default_nettype wire

/* verilog/pc_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module pc_sequencer import hwloop_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // pc stream
  output logic       pc_valid_o,
  input  logic       pc_ready_i,
  output hwlp_addr_t pc_o,
  output logic       pc_from_loop_o,
  // loop decision for the current pc
  input  logic       hwlp_jump_i,
  input  hwlp_addr_t hwlp_targ_addr_i,
  output logic       retire_o
);

  logic       valid_q;
  hwlp_addr_t pc_q;
  logic       from_loop_q;

  // a pc retires on its own handshake
  assign retire_o = valid_q && pc_ready_i;

  ////////////////////
  // pc register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      pc_q        <= hwlp_addr_t'(`HWLP_RESET_PC);
      from_loop_q <= 1'b0;
    end else begin
      // stream runs forever once out of reset
      valid_q <= 1'b1;
      if (retire_o) begin
        if (hwlp_jump_i) begin
          pc_q <= hwlp_targ_addr_i;
        end else begin
          pc_q <= pc_q + hwlp_addr_t'(4);
        end
        // marks the pc that a loop jump produced
        from_loop_q <= hwlp_jump_i;
      end
    end
  end

  assign pc_valid_o     = valid_q;
  assign pc_o           = pc_q;
  assign pc_from_loop_o = from_loop_q;

endmodule

`default_nettype wire

/* verilog/hwloop_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module hwloop_controller import hwloop_pkg::*; (
  input  hwlp_addr_t              cur_pc_i,
  input  logic                    retire_i,
  // loop register contents
  input  hwlp_addr_t              start_addr_i [`HWLP_N_REGS],
  input  hwlp_addr_t              end_addr_i   [`HWLP_N_REGS],
  input  hwlp_cnt_t               count_i      [`HWLP_N_REGS],
  // towards the sequencer
  output logic                    hwlp_jump_o,
  output hwlp_addr_t              hwlp_targ_addr_o,
  // towards regs and decoder
  output logic [`HWLP_N_REGS-1:0] dec_cnt_o
);

  hwlp_addr_t              next_pc;
  logic [`HWLP_N_REGS-1:0] match;
  logic [`HWLP_N_REGS-1:0] cnt_multi;

  // sequential successor of the retiring pc
  assign next_pc = cur_pc_i + hwlp_addr_t'(4);

  ////////////////////
  // end detection
  ////////////////////

  // one comparator per loop
  for (genvar g = 0; g < `HWLP_N_REGS; g++) begin : g_cmp
    // a count of zero never matches
    assign match[g] = retire_i
                    && (next_pc == end_addr_i[g])
                    && (count_i[g] != '0);
    // two or more left, so the body runs again
    assign cnt_multi[g] = (count_i[g] > hwlp_cnt_t'(1));
  end

  ////////////////////
  // priority pick
  ////////////////////

  // walk from the top so the lowest match is the last write
  always_comb begin
    dec_cnt_o        = '0;
    hwlp_jump_o      = 1'b0;
    hwlp_targ_addr_o = '0;
    for (int j = `HWLP_N_REGS-1; j >= 0; j--) begin
      if (match[j]) begin
        dec_cnt_o        = '0;
        dec_cnt_o[j]     = 1'b1;
        // last iteration falls through, counter still drops to zero
        hwlp_jump_o      = cnt_multi[j];
        hwlp_targ_addr_o = start_addr_i[j];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/hwloop_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module hwloop_regs import hwloop_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en_i,
  input  hwlp_op_e                wr_op_i,
  input  hwlp_idx_t               wr_idx_i,
  input  logic [31:0]             wr_data_i,
  input  logic [`HWLP_N_REGS-1:0] dec_cnt_i,
  output hwlp_addr_t              start_addr_o [`HWLP_N_REGS],
  output hwlp_addr_t              end_addr_o   [`HWLP_N_REGS],
  output hwlp_cnt_t               count_o      [`HWLP_N_REGS]
);

  hwlp_addr_t start_q [`HWLP_N_REGS];
  hwlp_addr_t end_q   [`HWLP_N_REGS];
  hwlp_cnt_t  count_q [`HWLP_N_REGS];

  // addresses are word aligned, low two bits dropped
  hwlp_addr_t wr_addr;
  assign wr_addr = hwlp_addr_t'(wr_data_i) & ~hwlp_addr_t'(3);

  ////////////////////
  // loop storage
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `HWLP_N_REGS; i++) begin
        start_q[i] <= '0;
        end_q[i]   <= '0;
        count_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `HWLP_N_REGS; i++) begin
        // command write, decoder keeps it away from a decrementing loop
        if (wr_en_i && wr_idx_i == hwlp_idx_t'(i)) begin
          case (wr_op_i)
            OP_SET_START: start_q[i] <= wr_addr;
            OP_SET_END:   end_q[i]   <= wr_addr;
            OP_SET_COUNT: count_q[i] <= hwlp_cnt_t'(wr_data_i);
            default: ;
          endcase
        end
        // one iteration consumed
        if (dec_cnt_i[i]) begin
          count_q[i] <= count_q[i] - hwlp_cnt_t'(1);
        end
      end
    end
  end

  assign start_addr_o = start_q;
  assign end_addr_o   = end_q;
  assign count_o      = count_q;

endmodule

`default_nettype wire

/* verilog/hwloop_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hwloop_config.svh"

module hwloop_cmd_decoder import hwloop_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  hwlp_op_e                cmd_op_i,
  input  hwlp_idx_t               cmd_idx_i,
  input  logic [31:0]             cmd_data_i,
  input  logic [`HWLP_N_REGS-1:0] dec_cnt_i,
  output logic                    wr_en_o,
  output hwlp_op_e                wr_op_o,
  output hwlp_idx_t               wr_idx_o,
  output logic [31:0]             wr_data_o
);

  // one-entry holding slot
  logic        slot_vld_q;
  hwlp_op_e    slot_op_q;
  hwlp_idx_t   slot_idx_q;
  logic [31:0] slot_data_q;

  logic conflict;
  logic drain;

  // the controller is decrementing the loop this write targets
  assign conflict = slot_vld_q && dec_cnt_i[slot_idx_q];
  assign drain    = slot_vld_q && !conflict;

  // accept into an empty slot or one that empties this cycle
  assign cmd_ready_o = !slot_vld_q || drain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_vld_q <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      slot_vld_q <= 1'b1;
    end else if (drain) begin
      slot_vld_q <= 1'b0;
    end
  end

  // payload only, qualified by slot_vld_q
  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) begin
      slot_op_q   <= cmd_op_i;
      slot_idx_q  <= cmd_idx_i;
      slot_data_q <= cmd_data_i;
    end
  end

  // write pulse towards the loop registers
  assign wr_en_o   = drain;
  assign wr_op_o   = slot_op_q;
  assign wr_idx_o  = slot_idx_q;
  assign wr_data_o = slot_data_q;

endmodule

`default_nettype wire

/* verilog/hwloop_pkg.sv */
`default_nettype none

package hwloop_pkg;

`include "hwloop_config.svh"

  // setup command opcodes, one field per command
  typedef enum logic [1:0] {
    OP_SET_START = 2'd0,
    OP_SET_END   = 2'd1,
    OP_SET_COUNT = 2'd2
  } hwlp_op_e;

  // index width, at least one bit even for a single loop
  localparam int unsigned HWLP_IDX_W = (`HWLP_N_REGS > 1) ? $clog2(`HWLP_N_REGS) : 1;

  typedef logic [`HWLP_ADDR_W-1:0] hwlp_addr_t;
  typedef logic [`HWLP_CNT_W-1:0]  hwlp_cnt_t;
  typedef logic [HWLP_IDX_W-1:0]   hwlp_idx_t;

endpackage

`default_nettype wire

/* verilog/hwloop_config.svh */
`ifndef HWLOOP_CONFIG_SVH
`define HWLOOP_CONFIG_SVH

// number of hardware loop registers
// loop 0 has the highest priority and is the inner loop
`define HWLP_N_REGS 2

// width of a pc, start address or end address
`define HWLP_ADDR_W 32

// width of the iteration counter
`define HWLP_CNT_W 32

// first pc presented after reset
`define HWLP_RESET_PC 32'h0000_0100

`endif
